// File: logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import rv_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  logic     fetch_valid,
	output logic     fetch_ready,
	input  word_t    fetch_pc,
	input  word_t    fetch_inst,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	input  word_t    rs1_data,
	input  word_t    rs2_data,
	input  logic     alu_busy_valid,
	input  reg_idx_t alu_busy_rd,
	input  logic     alu_busy_wen,
	input  logic     ret_busy_valid,
	input  reg_idx_t ret_busy_rd,
	input  logic     ret_busy_wen,
	output logic     issue_valid,
	input  logic     issue_ready,
	output issue_t   issue_data
);

	word_t     inst;
	word_t     pc;
	logic      hold_valid;
	op_class_e op_class;
	logic      need_rs1;
	logic      need_rs2;
	logic      alu_hazard;
	logic      ret_hazard;
	logic      fetch_fire;
	logic      issue_fire;

	assign fetch_fire  = fetch_valid & fetch_ready;
	assign issue_fire  = issue_valid & issue_ready;
	assign fetch_ready = ~hold_valid | issue_fire; // Refill in the cycle the held one leaves.

	always_ff @(posedge clock) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else if (fetch_fire) begin
			hold_valid <= 1'b1;
		end else if (issue_fire) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_fire) begin
			inst <= fetch_inst;
			pc   <= fetch_pc;
		end
	end

	assign rs1 = inst[18:15]; // RV32E, upper index bit is ignored.
	assign rs2 = inst[23:20];

	always_comb begin
		case (inst[6:0])
			opc_lui:    op_class = cls_lui;
			opc_auipc:  op_class = cls_auipc;
			opc_op_imm: op_class = cls_op_imm;
			opc_op:     op_class = cls_op;
			default:    op_class = cls_illegal;
		endcase
	end

	assign need_rs1 = (op_class == cls_op_imm) | (op_class == cls_op);
	assign need_rs2 = (op_class == cls_op);

	assign alu_hazard = alu_busy_valid & alu_busy_wen & (alu_busy_rd != 4'd0) &
		((need_rs1 & (alu_busy_rd == rs1)) | (need_rs2 & (alu_busy_rd == rs2)));
	assign ret_hazard = ret_busy_valid & ret_busy_wen & (ret_busy_rd != 4'd0) &
		((need_rs1 & (ret_busy_rd == rs1)) | (need_rs2 & (ret_busy_rd == rs2)));

	assign issue_valid = hold_valid & ~alu_hazard & ~ret_hazard;

	always_comb begin
		issue_data.pc      = pc;
		issue_data.rd      = inst[10:7];
		issue_data.reg_wen = (op_class != cls_illegal);
		issue_data.illegal = (op_class == cls_illegal);
		issue_data.src1    = rs1_data;
		issue_data.src2    = rs2_data;
		case (op_class)
			cls_lui:   issue_data.alu_op = op_lui;
			cls_auipc: issue_data.alu_op = op_auipc;
			cls_op:    issue_data.alu_op = op_add_reg;
			default:   issue_data.alu_op = op_add_imm;
		endcase
		if ((op_class == cls_lui) | (op_class == cls_auipc)) begin
			issue_data.imm = {inst[31:12], 12'b0}; // U-type.
		end else begin
			issue_data.imm = {{20{inst[31]}}, inst[31:20]}; // I-type.
		end
	end

	// An offered issue keeps its operands, so no in-flight write reaches them.
	a_issue_hold: assert property (@(posedge clock) disable iff (rst)
		issue_valid && !issue_ready |=> issue_valid && $stable(issue_data));

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import rv_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  logic     issue_valid,
	output logic     issue_ready,
	input  issue_t   issue_data,
	output logic     retire_valid,
	input  logic     retire_ready,
	output retire_t  retire_data,
	output logic     alu_busy_valid,
	output reg_idx_t alu_busy_rd,
	output logic     alu_busy_wen,
	output logic     ret_busy_valid,
	output reg_idx_t ret_busy_rd,
	output logic     ret_busy_wen
);

	issue_t  alu_data;
	logic    alu_ready;
	retire_t alu_result;

	pipe_slot #(.payload_t(issue_t)) alu_slot (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (issue_valid),
		.in_ready  (issue_ready),
		.in_data   (issue_data),
		.out_valid (alu_busy_valid),
		.out_ready (alu_ready),
		.out_data  (alu_data)
	);

	always_comb begin
		alu_result.pc      = alu_data.pc;
		alu_result.rd      = alu_data.rd;
		alu_result.reg_wen = alu_data.reg_wen;
		alu_result.illegal = alu_data.illegal;
		case (alu_data.alu_op)
			op_add_reg: alu_result.value = alu_data.src1 + alu_data.src2;
			op_add_imm: alu_result.value = alu_data.src1 + alu_data.imm;
			op_lui:     alu_result.value = alu_data.imm;
			default:    alu_result.value = alu_data.pc + alu_data.imm; // AUIPC.
		endcase
	end

	pipe_slot #(.payload_t(retire_t)) ret_slot (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (alu_busy_valid),
		.in_ready  (alu_ready),
		.in_data   (alu_result),
		.out_valid (retire_valid),
		.out_ready (retire_ready),
		.out_data  (retire_data)
	);

	assign alu_busy_rd    = alu_data.rd;
	assign alu_busy_wen   = alu_data.reg_wen;
	assign ret_busy_valid = retire_valid;
	assign ret_busy_rd    = retire_data.rd;
	assign ret_busy_wen   = retire_data.reg_wen;

endmodule

// File: logic/pipe_slot.sv
`timescale 1ns/100ps

module pipe_slot import rv_pkg::*; #(
	parameter type payload_t = word_t
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	assign in_ready = ~out_valid | out_ready; // Accept while draining.

	always_ff @(posedge clock) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	// Stalled output must hold until the consumer takes it.
	a_hold_stable: assert property (@(posedge clock) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    rs1_data,
	output word_t    rs2_data,
	input  logic     write_en,
	input  reg_idx_t write_rd,
	input  word_t    write_data
);

	word_t regs [16];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && (write_rd != 4'd0)) begin
			regs[write_rd] <= write_data;
		end
	end

	assign rs1_data = (rs1 == 4'd0) ? '0 : regs[rs1]; // x0 reads zero.
	assign rs2_data = (rs2 == 4'd0) ? '0 : regs[rs2];

	// Retired values reaching the array must be fully resolved.
	a_write_known: assert property (@(posedge clock) disable iff (rst)
		write_en |-> !$isunknown(write_data));

endmodule

// File: logic/rv_core_front.sv
`timescale 1ns/100ps

module rv_core_front import rv_pkg::*; (
	input  logic    clock,
	input  logic    rst,
	input  logic    fetch_valid,
	output logic    fetch_ready,
	input  word_t   fetch_pc,
	input  word_t   fetch_inst,
	output logic    retire_valid,
	input  logic    retire_ready,
	output retire_t retire_data
);

	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rs1_data;
	word_t    rs2_data;
	logic     issue_valid;
	logic     issue_ready;
	issue_t   issue_data;
	logic     alu_busy_valid;
	reg_idx_t alu_busy_rd;
	logic     alu_busy_wen;
	logic     ret_busy_valid;
	reg_idx_t ret_busy_rd;
	logic     ret_busy_wen;
	logic     write_en;

	// Register write happens on the retire edge.
	assign write_en = retire_valid & retire_ready & retire_data.reg_wen;

	decode_stage decode0 (
		.clock          (clock),
		.rst            (rst),
		.fetch_valid    (fetch_valid),
		.fetch_ready    (fetch_ready),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst),
		.rs1            (rs1),
		.rs2            (rs2),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.alu_busy_valid (alu_busy_valid),
		.alu_busy_rd    (alu_busy_rd),
		.alu_busy_wen   (alu_busy_wen),
		.ret_busy_valid (ret_busy_valid),
		.ret_busy_rd    (ret_busy_rd),
		.ret_busy_wen   (ret_busy_wen),
		.issue_valid    (issue_valid),
		.issue_ready    (issue_ready),
		.issue_data     (issue_data)
	);

	reg_file regs0 (
		.clock      (clock),
		.rst        (rst),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.write_en   (write_en),
		.write_rd   (retire_data.rd),
		.write_data (retire_data.value)
	);

	execute_stage exec0 (
		.clock          (clock),
		.rst            (rst),
		.issue_valid    (issue_valid),
		.issue_ready    (issue_ready),
		.issue_data     (issue_data),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_data    (retire_data),
		.alu_busy_valid (alu_busy_valid),
		.alu_busy_rd    (alu_busy_rd),
		.alu_busy_wen   (alu_busy_wen),
		.ret_busy_valid (ret_busy_valid),
		.ret_busy_rd    (ret_busy_rd),
		.ret_busy_wen   (ret_busy_wen)
	);

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

	typedef logic [3:0]  reg_idx_t;
	typedef logic [31:0] word_t;

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	typedef enum logic [2:0] {
		cls_lui,
		cls_auipc,
		cls_op_imm, // Whole OP-IMM group runs as ADDI.
		cls_op,
		cls_illegal
	} op_class_e;

	typedef enum logic [1:0] {
		op_add_reg,
		op_add_imm,
		op_lui,
		op_auipc
	} alu_op_e;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		logic     reg_wen;
		logic     illegal;
		alu_op_e  alu_op;
		word_t    src1;
		word_t    src2;
		word_t    imm;
	} issue_t;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		logic     reg_wen;
		logic     illegal;
		word_t    value;
	} retire_t;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_core_front -f verilog.f \
	--Mdir obj_dir -o sim_core_front
./obj_dir/sim_core_front | tee sim.log
if grep -q "^Result: PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: verification/tb_core_front.sv
`timescale 1ns/100ps

module tb_core_front import rv_pkg::*; ();

	localparam int num_entries = 20;
	localparam int max_cycles  = 10 * num_entries + 100;

	logic    clock        = 1'b0;
	logic    rst          = 1'b1;
	logic    fetch_valid  = 1'b0;
	logic    fetch_ready;
	word_t   fetch_pc     = '0;
	word_t   fetch_inst   = '0;
	logic    retire_valid;
	logic    retire_ready = 1'b0;
	retire_t retire_data;

	word_t       tdata [num_entries * 6]; // Six columns per instruction.
	logic [15:0] lfsr      = 16'd8256;
	int          fetch_idx = 0;
	int          ret_idx   = 0;
	int          errors    = 0;
	int          cycles    = 0;

	rv_core_front dut0 (.*);

	always #4 clock = ~clock;

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10]; // x^16+x^14+x^13+x^11+1.
		return {state[14:0], feedback};
	endfunction

	task automatic compare_field(input string name, input int col, input word_t got);
		word_t exp;
		exp = tdata[ret_idx * 6 + col];
		assert (got === exp) else begin
			errors++;
			$display("ERROR retire_data.%s got 0x%08h expected 0x%08h at instruction %0d",
				name, got, exp, ret_idx);
		end
	endtask

	// Fetch source and retire back-pressure.
	always @(posedge clock) begin
		if (!rst && (fetch_idx == ret_idx)) begin // Empty pipeline must accept.
			assert (fetch_ready === 1'b1) else begin
				errors++;
				$display("ERROR fetch_ready got 0x%0h expected 0x1 with nothing in flight",
					fetch_ready);
			end
		end
		if (rst) begin
			fetch_idx = 0;
		end else if (fetch_valid && fetch_ready) begin
			fetch_idx++;
		end
		fetch_valid <= !rst && (fetch_idx < num_entries);
		if (fetch_idx < num_entries) begin
			fetch_pc   <= tdata[fetch_idx * 6];
			fetch_inst <= tdata[fetch_idx * 6 + 1];
		end
		lfsr = lfsr_step(lfsr);
		retire_ready <= lfsr[0];
	end

	always @(posedge clock) begin
		if (!rst && retire_valid && retire_ready) begin
			assert (ret_idx < num_entries) else begin
				errors++;
				$display("Unexpected retirement with pc 0x%08h after the last instruction",
					retire_data.pc);
			end
			if (ret_idx < num_entries) begin
				compare_field("pc", 0, retire_data.pc);
				compare_field("reg_wen", 3, {31'h0, retire_data.reg_wen});
				compare_field("illegal", 4, {31'h0, retire_data.illegal});
				if (tdata[ret_idx * 6 + 4] == '0) begin // Illegal words carry no result.
					compare_field("rd", 2, {28'h0, retire_data.rd});
					compare_field("value", 5, retire_data.value);
				end
			end
			ret_idx <= ret_idx + 1;
		end
	end

	initial begin
		$readmemh("verification/testdata_alu.txt", tdata);
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		while ((ret_idx < num_entries) && (cycles < max_cycles)) begin
			@(posedge clock);
			cycles++;
		end
		assert (ret_idx >= num_entries) else begin
			errors++;
			$display("Timeout after %0d cycles with %0d of %0d instructions retired",
				cycles, ret_idx, num_entries);
		end
		repeat (4) @(negedge clock); // Leave room for a stray retirement.
		$display("Retired %0d of %0d instructions with %0d errors", ret_idx, num_entries, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verification/testdata_alu.txt
// pc inst rd reg_wen illegal value, all in hex
// rd and value are zero and unchecked on illegal rows
00000100 123450b7 1 1 0 12345000
00000104 67808093 1 1 0 12345678
00000108 fff00113 2 1 0 ffffffff
0000010c 002081b3 3 1 0 12345677
00000110 00001217 4 1 0 00001110
00000114 004002b3 5 1 0 00001110
00000118 00528013 0 1 0 00001115
0000011c 00000333 6 1 0 00000000
00000120 00112023 0 0 1 00000000
00000124 00108463 0 0 1 00000000
00000128 000083b3 7 1 0 12345678
0000012c 007383b3 7 1 0 2468acf0
00000130 80038413 8 1 0 2468a4f0
00000134 008184b3 9 1 0 369cfb67
00000138 fffff537 a 1 0 fffff000
0000013c 7ff50513 a 1 0 fffff7ff
00000140 80000597 b 1 0 80000140
00000144 00a58633 c 1 0 7ffff93f
00000148 00164693 d 1 0 7ffff940
0000014c 00668733 e 1 0 7ffff940

// File: verilog.f
logic/rv_pkg.sv
logic/pipe_slot.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_core_front.sv
verification/tb_core_front.sv
